// ==== common/emb_pkg.sv ====
`default_nettype none

package emb_pkg;

  // ------------------------------------------------------------
  // table geometry
  // ------------------------------------------------------------

  // rows in the table, one memory word each
  localparam int CHAR_NUM = 16;
  // lanes per row
  localparam int EMB_DIM = 4;
  // bits per lane
  localparam int N_LEN_W = 16;
  // row address width
  localparam int ADDR_W = 4;

  // tokens carried by a forward or backward command
  localparam int N = 2;
  localparam int TOK_W = 8;
  localparam int TOK_IDX_W = (N > 1) ? $clog2(N) : 1;

  // momentum decay and learning rate as arithmetic shifts
  localparam int MOM_SHIFT = 1;
  localparam int LR_SHIFT = 2;

  // ------------------------------------------------------------
  // data types
  // ------------------------------------------------------------

  typedef logic signed [N_LEN_W-1:0] emb_lane_t;

  // one memory word, lane 0 in the low bits
  typedef emb_lane_t [EMB_DIM-1:0] emb_row_t;

  typedef logic [TOK_W-1:0] emb_tok_t;
  typedef emb_tok_t [N-1:0] emb_toks_t;
  typedef emb_row_t [N-1:0] emb_rows_t;

  typedef enum logic [2:0] {
    op_load,
    op_zero_grad,
    op_forward,
    op_backward,
    op_update
  } emb_op_e;

  // load: rows[0] goes to row tokens[0]
  // backward: rows are the incoming gradients
  typedef struct packed {
    emb_op_e   op;
    emb_toks_t tokens;
    emb_rows_t rows;
  } emb_cmd_t;

  // forward result, one row per token
  typedef struct packed {
    emb_rows_t rows;
  } emb_rsp_t;

  // top level command sequencer
  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } emb_state_e;

endpackage

`default_nettype wire

// ==== logic/emb_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_ram (
  input  logic                      clk,
  input  logic                      we,
  input  logic [emb_pkg::ADDR_W-1:0] waddr,
  input  emb_pkg::emb_row_t         wdata,
  input  logic [emb_pkg::ADDR_W-1:0] raddr,
  output emb_pkg::emb_row_t         rdata
);

  import emb_pkg::*;

  emb_row_t mem [CHAR_NUM];

  // read before write on the same address gives the old row
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== emb_layer/emb_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_forward (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  emb_pkg::emb_toks_t         tokens,
  output logic [emb_pkg::ADDR_W-1:0] raddr,
  input  emb_pkg::emb_row_t          rdata,
  output emb_pkg::emb_rsp_t          q,
  output logic                       done
);

  import emb_pkg::*;

  localparam logic [TOK_IDX_W-1:0] LAST_IDX = TOK_IDX_W'(N - 1);

  // issue stage
  logic                 act;
  logic [TOK_IDX_W-1:0] idx;

  // capture stage, one cycle behind
  logic                 cap_vld;
  logic [TOK_IDX_W-1:0] cap_idx;

  assign raddr = tokens[idx][ADDR_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      act     <= 1'b0;
      idx     <= '0;
      cap_vld <= 1'b0;
      cap_idx <= '0;
      done    <= 1'b0;
    end else begin
      if (start) begin
        act <= 1'b1;
        idx <= '0;
      end else if (act) begin
        idx <= idx + 1'b1;
        if (idx == LAST_IDX) begin
          act <= 1'b0;
        end
      end
      cap_vld <= act;
      cap_idx <= idx;
      // q is complete once the last slot is written
      done    <= cap_vld && (cap_idx == LAST_IDX);
    end
  end

  // slot capture, next read already in flight
  always_ff @(posedge clk) begin
    if (cap_vld) begin
      q.rows[cap_idx] <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== emb_layer/emb_backward.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_backward (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  emb_pkg::emb_toks_t         tokens,
  input  emb_pkg::emb_rows_t         grads,
  output logic [emb_pkg::ADDR_W-1:0] raddr,
  input  emb_pkg::emb_row_t          rdata,
  output logic                       we,
  output logic [emb_pkg::ADDR_W-1:0] waddr,
  output emb_pkg::emb_row_t          wdata,
  output logic                       done
);

  import emb_pkg::*;

  localparam logic [TOK_IDX_W-1:0] LAST_IDX = TOK_IDX_W'(N - 1);

  typedef enum logic [1:0] {
    bw_idle,
    bw_read,
    bw_add,
    bw_write
  } bw_phase_e;

  bw_phase_e            phase;
  logic [TOK_IDX_W-1:0] idx;
  logic [ADDR_W-1:0]    tok_addr;
  emb_row_t             sum;
  emb_row_t             sum_q;

  // read and write hit the same row of the current token
  assign tok_addr = tokens[idx][ADDR_W-1:0];
  assign raddr    = tok_addr;
  assign waddr    = tok_addr;
  assign wdata    = sum_q;
  assign we       = (phase == bw_write);
  assign done     = (phase == bw_write) && (idx == LAST_IDX);

  // lane-wise wrapping add
  always_comb begin
    for (int l = 0; l < EMB_DIM; l++) begin
      sum[l] = rdata[l] + grads[idx][l];
    end
  end

  // ------------------------------------------------------------
  // read, add, write per token
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= bw_idle;
      idx   <= '0;
    end else begin
      case (phase)
        bw_idle: begin
          if (start) begin
            phase <= bw_read;
            idx   <= '0;
          end
        end
        bw_read:  phase <= bw_add;
        bw_add:   phase <= bw_write;
        bw_write: begin
          // next read only after this write lands, repeats accumulate
          if (idx == LAST_IDX) begin
            phase <= bw_idle;
          end else begin
            phase <= bw_read;
            idx   <= idx + 1'b1;
          end
        end
        default: phase <= bw_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == bw_add) begin
      sum_q <= sum;
    end
  end

endmodule

`default_nettype wire

// ==== emb_layer/emb_optim.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_optim (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  output logic [emb_pkg::ADDR_W-1:0] raddr,
  input  emb_pkg::emb_row_t          w_rdata,
  input  emb_pkg::emb_row_t          v_rdata,
  input  emb_pkg::emb_row_t          g_rdata,
  output logic                       we,
  output logic [emb_pkg::ADDR_W-1:0] waddr,
  output emb_pkg::emb_row_t          w_wdata,
  output emb_pkg::emb_row_t          v_wdata,
  output logic                       done
);

  import emb_pkg::*;

  localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(CHAR_NUM - 1);

  // read stage
  logic              rd_act;
  logic [ADDR_W-1:0] rd_addr;

  // compute stage, read data valid here
  logic              cmp_vld;
  logic [ADDR_W-1:0] cmp_addr;
  emb_row_t          v_new;
  emb_row_t          w_new;

  assign raddr = rd_addr;
  assign done  = we && (waddr == LAST_ROW);

  // ------------------------------------------------------------
  // momentum SGD per lane
  // ------------------------------------------------------------
  always_comb begin
    for (int l = 0; l < EMB_DIM; l++) begin
      v_new[l] = (v_rdata[l] >>> MOM_SHIFT) + g_rdata[l];
      w_new[l] = w_rdata[l] - (v_new[l] >>> LR_SHIFT);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_act   <= 1'b0;
      rd_addr  <= '0;
      cmp_vld  <= 1'b0;
      cmp_addr <= '0;
      we       <= 1'b0;
      waddr    <= '0;
    end else begin
      if (start) begin
        rd_act  <= 1'b1;
        rd_addr <= '0;
      end else if (rd_act) begin
        rd_addr <= rd_addr + 1'b1;
        if (rd_addr == LAST_ROW) begin
          rd_act <= 1'b0;
        end
      end
      cmp_vld  <= rd_act;
      cmp_addr <= rd_addr;
      we       <= cmp_vld;
      waddr    <= cmp_addr;
    end
  end

  // write data follows the compute stage by one cycle
  always_ff @(posedge clk) begin
    if (cmp_vld) begin
      w_wdata <= w_new;
      v_wdata <= v_new;
    end
  end

endmodule

`default_nettype wire

// ==== emb_layer/emb_layer.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_layer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  emb_pkg::emb_cmd_t cmd,
  output logic              ack,
  output emb_pkg::emb_rsp_t rsp
);

  import emb_pkg::*;

  // ------------------------------------------------------------
  // declarations
  // ------------------------------------------------------------

  // sequencer and latched command
  emb_state_e        state;
  emb_op_e           op_q;
  emb_toks_t         toks_q;
  emb_rows_t         rows_q;
  emb_toks_t         tok_buf;
  logic              accept;
  logic              start_q;
  logic              unit_done;

  // row load
  logic              load_we;
  logic              load_done;
  logic [ADDR_W-1:0] ld_addr;

  // zero-grad sweep
  logic              zg_busy;
  logic [ADDR_W-1:0] zg_addr;
  logic              zg_done;

  // unit handshakes
  logic              fwd_start;
  logic              fwd_done;
  logic              bwd_start;
  logic              bwd_done;
  logic              opt_start;
  logic              opt_done;

  // unit memory ports
  logic [ADDR_W-1:0] fwd_raddr;
  emb_rsp_t          fwd_q;
  logic [ADDR_W-1:0] bwd_raddr;
  logic              bwd_we;
  logic [ADDR_W-1:0] bwd_waddr;
  emb_row_t          bwd_wdata;
  logic [ADDR_W-1:0] opt_raddr;
  logic              opt_we;
  logic [ADDR_W-1:0] opt_waddr;
  emb_row_t          opt_w_wdata;
  emb_row_t          opt_v_wdata;

  // memory side
  logic              w_we;
  logic [ADDR_W-1:0] w_waddr;
  emb_row_t          w_wdata;
  logic [ADDR_W-1:0] w_raddr;
  emb_row_t          w_rdata;
  logic              v_we;
  logic [ADDR_W-1:0] v_waddr;
  emb_row_t          v_wdata;
  emb_row_t          v_rdata;
  logic              g_we;
  logic [ADDR_W-1:0] g_waddr;
  emb_row_t          g_wdata;
  logic [ADDR_W-1:0] g_raddr;
  emb_row_t          g_rdata;

  // ------------------------------------------------------------
  // command sequencer
  // ------------------------------------------------------------
  assign accept    = (state == idle) && req;
  assign ack       = (state == done);
  assign unit_done = load_done | zg_done | fwd_done | bwd_done | opt_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      op_q    <= op_load;
      start_q <= 1'b0;
      tok_buf <= '0;
    end else begin
      start_q <= accept;
      case (state)
        idle: begin
          if (req) begin
            state <= busy;
            op_q  <= cmd.op;
            // backward later uses the tokens of this forward
            if (cmd.op == op_forward) begin
              tok_buf <= cmd.tokens;
            end
          end
        end
        busy: begin
          if (unit_done) begin
            state <= done;
          end
        end
        done: begin
          if (!req) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // cmd sampled once, on the first req cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      toks_q <= cmd.tokens;
      rows_q <= cmd.rows;
    end
  end

  always_ff @(posedge clk) begin
    if (fwd_done) begin
      rsp <= fwd_q;
    end
  end

  assign fwd_start = start_q && (op_q == op_forward);
  assign bwd_start = start_q && (op_q == op_backward);
  assign opt_start = start_q && (op_q == op_update);

  // ------------------------------------------------------------
  // load and zero-grad
  // ------------------------------------------------------------
  assign load_we = start_q && (op_q == op_load);
  assign ld_addr = toks_q[0][ADDR_W-1:0];
  assign zg_done = zg_busy && (zg_addr == ADDR_W'(CHAR_NUM - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_done <= 1'b0;
      zg_busy   <= 1'b0;
      zg_addr   <= '0;
    end else begin
      load_done <= load_we;
      if (start_q && (op_q == op_zero_grad)) begin
        zg_busy <= 1'b1;
        zg_addr <= '0;
      end else if (zg_busy) begin
        zg_addr <= zg_addr + 1'b1;
        if (zg_done) begin
          zg_busy <= 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // memory port mux, by opcode of the active command
  // ------------------------------------------------------------
  always_comb begin
    w_we    = 1'b0;
    w_waddr = opt_waddr;
    w_wdata = opt_w_wdata;
    w_raddr = opt_raddr;
    v_we    = 1'b0;
    v_waddr = opt_waddr;
    v_wdata = opt_v_wdata;
    g_we    = 1'b0;
    g_waddr = bwd_waddr;
    g_wdata = bwd_wdata;
    g_raddr = bwd_raddr;
    case (op_q)
      op_load: begin
        // new weight row, momentum cleared
        w_we    = load_we;
        w_waddr = ld_addr;
        w_wdata = rows_q[0];
        v_we    = load_we;
        v_waddr = ld_addr;
        v_wdata = '0;
      end
      op_zero_grad: begin
        g_we    = zg_busy;
        g_waddr = zg_addr;
        g_wdata = '0;
      end
      op_forward:  w_raddr = fwd_raddr;
      op_backward: g_we = bwd_we;
      op_update: begin
        w_we    = opt_we;
        v_we    = opt_we;
        g_raddr = opt_raddr;
      end
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // units and memories
  // ------------------------------------------------------------
  emb_forward u_forward (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (fwd_start),
    .tokens (toks_q),
    .raddr  (fwd_raddr),
    .rdata  (w_rdata),
    .q      (fwd_q),
    .done   (fwd_done)
  );

  emb_backward u_backward (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (bwd_start),
    .tokens (tok_buf),
    .grads  (rows_q),
    .raddr  (bwd_raddr),
    .rdata  (g_rdata),
    .we     (bwd_we),
    .waddr  (bwd_waddr),
    .wdata  (bwd_wdata),
    .done   (bwd_done)
  );

  emb_optim u_optim (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (opt_start),
    .raddr   (opt_raddr),
    .w_rdata (w_rdata),
    .v_rdata (v_rdata),
    .g_rdata (g_rdata),
    .we      (opt_we),
    .waddr   (opt_waddr),
    .w_wdata (opt_w_wdata),
    .v_wdata (opt_v_wdata),
    .done    (opt_done)
  );

  emb_ram ram_w (
    .clk   (clk),
    .we    (w_we),
    .waddr (w_waddr),
    .wdata (w_wdata),
    .raddr (w_raddr),
    .rdata (w_rdata)
  );

  // momentum is only read by the optimizer
  emb_ram ram_v (
    .clk   (clk),
    .we    (v_we),
    .waddr (v_waddr),
    .wdata (v_wdata),
    .raddr (opt_raddr),
    .rdata (v_rdata)
  );

  emb_ram ram_grad (
    .clk   (clk),
    .we    (g_we),
    .waddr (g_waddr),
    .wdata (g_wdata),
    .raddr (g_raddr),
    .rdata (g_rdata)
  );

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  // 4 ns period
  localparam int HALF_PERIOD_NS = 2;
  localparam int RESET_CYCLES   = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/emb_layer_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_layer_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              req,
  input logic              ack,
  input emb_pkg::emb_cmd_t cmd
);

  // failed assertions so far
  int fail_count = 0;

  // ------------------------------------------------------------
  // four-phase handshake
  // ------------------------------------------------------------

  // ack is raised on an edge where req is still high
  ack_rise_with_req: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
  ) else begin
    fail_count++;
    $error("ack rose while req was low");
  end

  // ack drops only once the host has released req
  ack_fall_after_req: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req)
  ) else begin
    fail_count++;
    $error("ack fell while req was still high");
  end

  cmd_stable_in_req: assert property (
    @(posedge clk) disable iff (!rst_n) (req && $past(req) && !ack) |-> $stable(cmd)
  ) else begin
    fail_count++;
    $error("cmd changed while req was high and ack low");
  end

  ack_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !ack
  ) else begin
    fail_count++;
    $error("ack was high when reset was released");
  end

endmodule

bind emb_layer emb_layer_checker u_checker (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .ack   (ack),
  .cmd   (cmd)
);

`default_nettype wire

// ==== test/emb_layer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module emb_layer_tb;

  import emb_pkg::*;

  localparam int DIRECTED_CMDS  = 64;
  localparam int RANDOM_CMDS    = 200;
  localparam int CYCLES_PER_CMD = 64;

  logic        clk;
  logic        rst_n;
  logic        req;
  emb_cmd_t    cmd;
  logic        ack;
  emb_rsp_t    rsp;

  // reference model of the three memories and the token buffer
  emb_row_t    ref_w [CHAR_NUM];
  emb_row_t    ref_v [CHAR_NUM];
  emb_row_t    ref_g [CHAR_NUM];
  emb_toks_t   ref_toks;

  emb_rsp_t    exp_rsp;
  logic        fwd_pending;
  int          cmd_count;
  logic [31:0] lfsr_q;

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  emb_layer DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .cmd   (cmd),
    .ack   (ack),
    .rsp   (rsp)
  );

  // ------------------------------------------------------------
  // random source
  // ------------------------------------------------------------

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic emb_row_t rand_row();
    emb_row_t r;
    for (int l = 0; l < EMB_DIM; l++) begin
      r[l] = N_LEN_W'(rand_bits(N_LEN_W));
    end
    return r;
  endfunction

  function automatic emb_rows_t rand_rows();
    emb_rows_t g;
    for (int i = 0; i < N; i++) begin
      g[i] = rand_row();
    end
    return g;
  endfunction

  // tokens stay inside the table
  function automatic emb_toks_t rand_toks();
    emb_toks_t t;
    for (int i = 0; i < N; i++) begin
      t[i] = emb_tok_t'(rand_bits(ADDR_W));
    end
    return t;
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  function automatic emb_rsp_t ref_forward(input emb_toks_t toks);
    emb_rsp_t r;
    for (int i = 0; i < N; i++) begin
      r.rows[i] = ref_w[toks[i][ADDR_W-1:0]];
    end
    return r;
  endfunction

  // gradients go to the rows of the last forward, in token order
  function automatic void ref_backward(input emb_rows_t grads);
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < N; i++) begin
      a = ref_toks[i][ADDR_W-1:0];
      for (int l = 0; l < EMB_DIM; l++) begin
        ref_g[a][l] = ref_g[a][l] + grads[i][l];
      end
    end
  endfunction

  // v = (v >>> MOM_SHIFT) + g, then w = w - (v >>> LR_SHIFT)
  function automatic void ref_update();
    emb_lane_t v_new;
    for (int r = 0; r < CHAR_NUM; r++) begin
      for (int l = 0; l < EMB_DIM; l++) begin
        v_new       = (ref_v[r][l] >>> MOM_SHIFT) + ref_g[r][l];
        ref_v[r][l] = v_new;
        ref_w[r][l] = ref_w[r][l] - (v_new >>> LR_SHIFT);
      end
    end
  endfunction

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [N_LEN_W-1:0] got,
                             input logic [N_LEN_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // rsp is compared on the falling edge where ack is seen high
  always @(negedge clk) begin
    if (DUT.u_checker.fail_count != 0) begin
      $display("a handshake assertion failed in the bound checker");
      $display("TEST RESULT: FAIL");
      $fatal(1, "handshake assertion failed");
    end else if (ack && fwd_pending) begin
      for (int i = 0; i < N; i++) begin
        for (int l = 0; l < EMB_DIM; l++) begin
          check_value($sformatf("rsp.rows[%0d][%0d]", i, l), rsp.rows[i][l],
                      exp_rsp.rows[i][l]);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // command tasks
  // ------------------------------------------------------------

  task automatic run_cmd(input emb_cmd_t c);
    @(negedge clk);
    cmd = c;
    req = 1'b1;
    cmd_count++;
    @(negedge clk);
    while (!ack) begin
      @(negedge clk);
    end
    req = 1'b0;
    @(negedge clk);
    while (ack) begin
      @(negedge clk);
    end
  endtask

  task automatic do_load(input logic [ADDR_W-1:0] a, input emb_row_t row);
    emb_cmd_t c;
    c           = '0;
    c.op        = op_load;
    c.tokens[0] = emb_tok_t'(a);
    c.rows[0]   = row;
    ref_w[a]    = row;
    ref_v[a]    = '0;
    run_cmd(c);
  endtask

  task automatic do_zero_grad();
    emb_cmd_t c;
    c    = '0;
    c.op = op_zero_grad;
    for (int r = 0; r < CHAR_NUM; r++) begin
      ref_g[r] = '0;
    end
    run_cmd(c);
  endtask

  task automatic do_forward(input emb_toks_t toks);
    emb_cmd_t c;
    c           = '0;
    c.op        = op_forward;
    c.tokens    = toks;
    exp_rsp     = ref_forward(toks);
    ref_toks    = toks;
    fwd_pending = 1'b1;
    run_cmd(c);
    fwd_pending = 1'b0;
  endtask

  // cmd_toks go out on the bus but must be ignored by the DUT
  task automatic do_backward(input emb_rows_t grads, input emb_toks_t cmd_toks);
    emb_cmd_t c;
    c        = '0;
    c.op     = op_backward;
    c.tokens = cmd_toks;
    c.rows   = grads;
    ref_backward(grads);
    run_cmd(c);
  endtask

  task automatic do_update();
    emb_cmd_t c;
    c    = '0;
    c.op = op_update;
    ref_update();
    run_cmd(c);
  endtask

  // every row once, in pairs
  task automatic forward_all();
    emb_toks_t toks;
    for (int p = 0; p < CHAR_NUM / N; p++) begin
      for (int i = 0; i < N; i++) begin
        toks[i] = emb_tok_t'(p * N + i);
      end
      do_forward(toks);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin
    emb_toks_t toks;
    emb_toks_t other;
    int        sel;
    req         = 1'b0;
    cmd         = '0;
    fwd_pending = 1'b0;
    cmd_count   = 0;
    lfsr_q      = 32'h36935172;
    ref_toks    = '0;

    @(posedge rst_n);
    @(negedge clk);
    check_value("ack", N_LEN_W'(ack), '0);

    // load every row, then read them back
    for (int r = 0; r < CHAR_NUM; r++) begin
      do_load(ADDR_W'(r), rand_row());
    end
    forward_all();
    for (int k = 0; k < 4; k++) begin
      do_forward(rand_toks());
    end

    // repeated token accumulates twice before the update
    do_zero_grad();
    toks    = rand_toks();
    toks[1] = toks[0];
    do_forward(toks);
    do_backward(rand_rows(), toks);
    do_update();
    forward_all();

    // decayed momentum with the kept gradient
    do_update();
    forward_all();

    // backward follows the buffered forward tokens
    do_zero_grad();
    toks = rand_toks();
    do_forward(toks);
    for (int i = 0; i < N; i++) begin
      other[i] = toks[i] ^ emb_tok_t'(8'h0f);
    end
    do_backward(rand_rows(), other);
    do_update();
    forward_all();

    // random mix
    for (int k = 0; k < RANDOM_CMDS; k++) begin
      sel = int'(rand_bits(3));
      case (sel)
        0:       do_load(ADDR_W'(rand_bits(ADDR_W)), rand_row());
        1:       do_zero_grad();
        2, 3, 7: do_forward(rand_toks());
        4, 5:    do_backward(rand_rows(), rand_toks());
        default: do_update();
      endcase
    end

    @(negedge clk);
    if (DUT.u_checker.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "handshake assertions failed");
    end
  end

  // budget of 64 cycles for each command
  initial begin
    repeat ((DIRECTED_CMDS + RANDOM_CMDS) * CYCLES_PER_CMD) @(posedge clk);
    $display("watchdog timeout after %0d commands, the DUT stopped answering", cmd_count);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== emb_layer.f ====
common/emb_pkg.sv
logic/emb_ram.sv
emb_layer/emb_forward.sv
emb_layer/emb_backward.sv
emb_layer/emb_optim.sv
emb_layer/emb_layer.sv
test/clk_gen.sv
test/emb_layer_checker.sv
test/emb_layer_tb.sv

// ==== Makefile ====
TOP = emb_layer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f emb_layer.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f emb_layer.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
